// File: src.f
+incdir+design
+incdir+verif
design/mapper_pkg.sv
design/bank_regs.sv
design/a12_edge_fsm.sv
design/irq_counter.sv
design/addr_translate.sv
design/mapper_top.sv
verif/tb_mapper.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the mapper testbench with verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module tb_mapper -o sim_mapper

# the log decides the result, so a fatal stop must not end the script here
./obj_dir/sim_mapper > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"

// File: verif/mapper_vectors.svh
`ifndef MAPPER_VECTORS_SVH
`define MAPPER_VECTORS_SVH

// columns: kind, opcode, address, data, expected, flags
// prg rows: data bit 0 is cpu_rw, expected is the 8 KB bank, flags {prg_ce, ram_ce, ram_we}
// chr rows: expected is the 1 KB bank, flags {ciram_ce, ciram_a10}
// burst rows: address holds the qualified fall count, data bit 0 adds a short pulse
// before each fall, expected is irq after the last fall

task fill_table;
begin
	// reset state, cfg_mir_v strapped high
	put_row(row_irq,   op_none,        16'h0000, 8'h00, 8'h00, 3'b000);
	put_row(row_prg,   op_none,        16'h8000, 8'h01, 8'h00, 3'b100);
	put_row(row_prg,   op_none,        16'hA000, 8'h01, 8'h01, 3'b100);
	put_row(row_prg,   op_none,        16'hC000, 8'h01, 8'h3E, 3'b100);
	put_row(row_prg,   op_none,        16'hE000, 8'h01, 8'h3F, 3'b100);
	put_row(row_prg,   op_none,        16'h6000, 8'h01, 8'h00, 3'b000);
	put_row(row_chr,   op_none,        16'h0000, 8'h00, 8'h00, 3'b010);
	put_row(row_chr,   op_none,        16'h0400, 8'h00, 8'h01, 3'b011);
	put_row(row_chr,   op_none,        16'h0800, 8'h00, 8'h02, 3'b010);
	put_row(row_chr,   op_none,        16'h1000, 8'h00, 8'h04, 3'b010);
	put_row(row_chr,   op_none,        16'h1C00, 8'h00, 8'h07, 3'b011);
	put_row(row_chr,   op_none,        16'h2400, 8'h00, 8'h01, 3'b001);
	put_row(row_chr,   op_none,        16'h2800, 8'h00, 8'h02, 3'b000);
	// prg banks in both modes
	put_row(row_write, op_bank_select, 16'h0000, 8'h06, 8'h00, 3'b000);
	put_row(row_write, op_bank_data,   16'h0000, 8'h15, 8'h00, 3'b000);
	put_row(row_write, op_bank_select, 16'h0000, 8'h07, 8'h00, 3'b000);
	put_row(row_write, op_bank_data,   16'h0000, 8'h2A, 8'h00, 3'b000);
	put_row(row_prg,   op_none,        16'h8000, 8'h01, 8'h15, 3'b100);
	put_row(row_prg,   op_none,        16'hA000, 8'h01, 8'h2A, 3'b100);
	put_row(row_prg,   op_none,        16'hC000, 8'h01, 8'h3E, 3'b100);
	put_row(row_write, op_bank_select, 16'h0000, 8'h46, 8'h00, 3'b000);
	put_row(row_write, op_bank_data,   16'h0000, 8'h09, 8'h00, 3'b000);
	put_row(row_prg,   op_none,        16'h8000, 8'h01, 8'h3E, 3'b100);
	put_row(row_prg,   op_none,        16'hA000, 8'h01, 8'h2A, 3'b100);
	put_row(row_prg,   op_none,        16'hC000, 8'h01, 8'h09, 3'b100);
	put_row(row_prg,   op_none,        16'hE000, 8'h01, 8'h3F, 3'b100);
	// chr banks, bank 1 gets an odd value so the dropped bit shows
	put_row(row_write, op_bank_select, 16'h0000, 8'h00, 8'h00, 3'b000);
	put_row(row_write, op_bank_data,   16'h0000, 8'h20, 8'h00, 3'b000);
	put_row(row_write, op_bank_select, 16'h0000, 8'h01, 8'h00, 3'b000);
	put_row(row_write, op_bank_data,   16'h0000, 8'h31, 8'h00, 3'b000);
	put_row(row_write, op_bank_select, 16'h0000, 8'h02, 8'h00, 3'b000);
	put_row(row_write, op_bank_data,   16'h0000, 8'h40, 8'h00, 3'b000);
	put_row(row_write, op_bank_select, 16'h0000, 8'h03, 8'h00, 3'b000);
	put_row(row_write, op_bank_data,   16'h0000, 8'h41, 8'h00, 3'b000);
	put_row(row_write, op_bank_select, 16'h0000, 8'h04, 8'h00, 3'b000);
	put_row(row_write, op_bank_data,   16'h0000, 8'h42, 8'h00, 3'b000);
	put_row(row_write, op_bank_select, 16'h0000, 8'h05, 8'h00, 3'b000);
	put_row(row_write, op_bank_data,   16'h0000, 8'h83, 8'h00, 3'b000);
	put_row(row_chr,   op_none,        16'h0000, 8'h00, 8'h20, 3'b010);
	put_row(row_chr,   op_none,        16'h0800, 8'h00, 8'h30, 3'b010);
	put_row(row_chr,   op_none,        16'h1000, 8'h00, 8'h40, 3'b010);
	put_row(row_chr,   op_none,        16'h1C00, 8'h00, 8'h83, 3'b011);
	// chr halves swapped
	put_row(row_write, op_bank_select, 16'h0000, 8'h80, 8'h00, 3'b000);
	put_row(row_chr,   op_none,        16'h0000, 8'h00, 8'h40, 3'b010);
	put_row(row_chr,   op_none,        16'h0C00, 8'h00, 8'h83, 3'b011);
	put_row(row_chr,   op_none,        16'h1000, 8'h00, 8'h20, 3'b010);
	put_row(row_chr,   op_none,        16'h1C00, 8'h00, 8'h31, 3'b011);
	// mirroring and work ram
	put_row(row_write, op_mirror,      16'h0000, 8'h01, 8'h00, 3'b000);
	put_row(row_chr,   op_none,        16'h2400, 8'h00, 8'h41, 3'b000);
	put_row(row_chr,   op_none,        16'h2800, 8'h00, 8'h42, 3'b001);
	put_row(row_write, op_mirror,      16'h0000, 8'h00, 8'h00, 3'b000);
	put_row(row_chr,   op_none,        16'h2800, 8'h00, 8'h42, 3'b000);
	put_row(row_write, op_ram_protect, 16'h0000, 8'h80, 8'h00, 3'b000);
	put_row(row_prg,   op_none,        16'h6000, 8'h01, 8'h00, 3'b010);
	put_row(row_prg,   op_none,        16'h6000, 8'h00, 8'h00, 3'b011);
	put_row(row_write, op_ram_protect, 16'h0000, 8'hC0, 8'h00, 3'b000);
	put_row(row_prg,   op_none,        16'h6000, 8'h00, 8'h00, 3'b010);
	// latch 2, irq after 24 falls
	put_row(row_write, op_irq_latch,   16'h0000, 8'h02, 8'h00, 3'b000);
	put_row(row_write, op_irq_reload,  16'h0000, 8'h00, 8'h00, 3'b000);
	put_row(row_write, op_irq_enable,  16'h0000, 8'h00, 8'h00, 3'b000);
	put_row(row_burst, op_none,        16'd23,   8'h00, 8'h00, 3'b000);
	put_row(row_burst, op_none,        16'd1,    8'h00, 8'h01, 3'b000);
	put_row(row_write, op_irq_disable, 16'h0000, 8'h00, 8'h00, 3'b000);
	put_row(row_irq,   op_none,        16'h0000, 8'h00, 8'h00, 3'b000);
	// latch 1 with glitches mixed in, still 16 falls
	put_row(row_write, op_irq_latch,   16'h0000, 8'h01, 8'h00, 3'b000);
	put_row(row_write, op_irq_reload,  16'h0000, 8'h00, 8'h00, 3'b000);
	put_row(row_write, op_irq_enable,  16'h0000, 8'h00, 8'h00, 3'b000);
	put_row(row_burst, op_none,        16'd15,   8'h01, 8'h00, 3'b000);
	put_row(row_burst, op_none,        16'd1,    8'h01, 8'h01, 3'b000);
	put_row(row_write, op_irq_disable, 16'h0000, 8'h00, 8'h00, 3'b000);
	put_row(row_irq,   op_none,        16'h0000, 8'h00, 8'h00, 3'b000);
end
endtask

`endif

// File: verif/tb_mapper.sv
`timescale 1ns/100ps
`default_nettype none

`include "mapper_params.svh"

module tb_mapper
	import mapper_pkg::*;
();

	typedef enum logic [2:0] {
		row_write,
		row_prg,
		row_chr,
		row_burst,
		row_irq
	} row_kind_t;

	typedef struct packed {
		row_kind_t   kind;
		map_op_t     op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [7:0]  exp;
		logic [2:0]  flags;
	} vec_row_t;

	localparam int irq_timeout = 16;

	logic        mai;
	logic        rst_n;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_data;
	logic        cpu_rw;
	logic        cpu_wr;
	logic [13:0] ppu_addr;
	logic        cfg_mir_v;
	wire  [18:0] prg_addr;
	wire         prg_ce;
	wire         ram_ce;
	wire         ram_we;
	wire  [17:0] chr_addr;
	wire         ciram_a10;
	wire         ciram_ce;
	wire         irq;

	vec_row_t vectors[$];
	int       err_cnt;

	`include "mapper_vectors.svh"

	mapper_top uut (
		.mai       (mai),
		.rst_n     (rst_n),
		.cpu_addr  (cpu_addr),
		.cpu_data  (cpu_data),
		.cpu_rw    (cpu_rw),
		.cpu_wr    (cpu_wr),
		.ppu_addr  (ppu_addr),
		.cfg_mir_v (cfg_mir_v),
		.prg_addr  (prg_addr),
		.prg_ce    (prg_ce),
		.ram_ce    (ram_ce),
		.ram_we    (ram_we),
		.chr_addr  (chr_addr),
		.ciram_a10 (ciram_a10),
		.ciram_ce  (ciram_ce),
		.irq       (irq)
	);

	initial
	begin
		mai = 1'b0;
		forever #2 mai = ~mai;
	end

	function automatic void put_row(
		input row_kind_t   kind,
		input map_op_t     op,
		input logic [15:0] addr,
		input logic [7:0]  data,
		input logic [7:0]  exp,
		input logic [2:0]  flags
	);
		vec_row_t r;
	begin
		r.kind  = kind;
		r.op    = op;
		r.addr  = addr;
		r.data  = data;
		r.exp   = exp;
		r.flags = flags;
		vectors.push_back(r);
	end
	endfunction

	// inputs change 1 ns after the rising edge
	task automatic step_cycle;
	begin
		@(posedge mai);
		#1;
	end
	endtask

	task automatic report_error(input string what);
	begin
		err_cnt++;
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1, "stopped at first error");
	end
	endtask

	task automatic check_prg(
		input logic [18:0] got_addr,
		input logic [18:0] exp_addr,
		input logic [2:0]  got_sel,
		input logic [2:0]  exp_sel,
		input logic        addr_valid,
		input string       where
	);
	begin
		if (got_sel !== exp_sel)
			report_error($sformatf("FAILED at %t: %s {prg_ce,ram_ce,ram_we} %b, expected %b",
				$time, where, got_sel, exp_sel));
		else if (addr_valid && got_addr !== exp_addr)
			report_error($sformatf("FAILED at %t: %s prg_addr %h, expected %h",
				$time, where, got_addr, exp_addr));
	end
	endtask

	task automatic check_chr(
		input logic [17:0] got_addr,
		input logic [17:0] exp_addr,
		input logic [1:0]  got_mir,
		input logic [1:0]  exp_mir,
		input string       where
	);
	begin
		if (got_addr !== exp_addr)
			report_error($sformatf("FAILED at %t: %s chr_addr %h, expected %h",
				$time, where, got_addr, exp_addr));
		else if (got_mir !== exp_mir)
			report_error($sformatf("FAILED at %t: %s {ciram_ce,ciram_a10} %b, expected %b",
				$time, where, got_mir, exp_mir));
	end
	endtask

	task automatic check_irq(input logic got, input logic exp, input string where);
	begin
		if (got !== exp)
			report_error($sformatf("FAILED at %t: %s irq %b, expected %b",
				$time, where, got, exp));
	end
	endtask

	// any mirror of the register address, low bits are random
	task automatic drive_cpu_write(input map_op_t op, input logic [7:0] data);
		logic [3:0]  code;
		logic [11:0] mirror;
	begin
		code     = op;
		mirror   = 12'($urandom());
		cpu_addr = {code[3:1], mirror, code[0]};
		cpu_data = data;
		cpu_rw   = 1'b0;
		cpu_wr   = 1'b1;
		ppu_addr = 14'h0000;
		step_cycle;
		cpu_wr   = 1'b0;
		cpu_rw   = 1'b1;
	end
	endtask

	task automatic probe_prg_slot(input vec_row_t row);
		logic [12:0] offset;
		logic [15:0] addr;
		logic [18:0] exp_addr;
	begin
		offset   = 13'($urandom());
		addr     = {row.addr[15:13], offset};
		exp_addr = {row.exp[`PRG_BANK_W-1:0], offset};
		cpu_addr = addr;
		cpu_rw   = row.data[0];
		#1;
		check_prg(prg_addr, exp_addr, {prg_ce, ram_ce, ram_we}, row.flags, row.flags[2],
			$sformatf("cpu %h", addr));
		step_cycle;
	end
	endtask

	task automatic probe_chr_addr(input vec_row_t row);
		logic [9:0]  offset;
		logic [13:0] addr;
		logic [17:0] exp_addr;
	begin
		offset   = 10'($urandom());
		addr     = {row.addr[13:10], offset};
		exp_addr = {row.exp[`CHR_BANK_W-1:0], offset};
		ppu_addr = addr;
		#1;
		check_chr(chr_addr, exp_addr, {ciram_ce, ciram_a10}, row.flags[1:0],
			$sformatf("ppu %h", addr));
		step_cycle;
	end
	endtask

	task automatic send_a12_pulse(input int high_cycles);
	begin
		ppu_addr = 14'h1000;
		repeat (high_cycles) step_cycle;
		ppu_addr = 14'h0000;
	end
	endtask

	task automatic await_irq(input logic exp);
		int waited;
	begin
		waited = 0;
		while (irq !== exp && waited < irq_timeout)
		begin
			step_cycle;
			waited++;
		end
		if (irq !== exp)
			report_error($sformatf("timeout: irq did not go to %0b within %0d cycles",
				exp, irq_timeout));
	end
	endtask

	task automatic run_a12_burst(input vec_row_t row);
		int falls;
	begin
		falls = int'(row.addr);
		for (int i = 0; i < falls; i++)
		begin
			// glitch, one cycle too short to count
			if (row.data[0])
			begin
				send_a12_pulse(`A12_MIN_HIGH - 1);
				repeat (2) step_cycle;
			end
			send_a12_pulse(`A12_MIN_HIGH);
			repeat (4) step_cycle;
			if (i < falls - 1 || !row.exp[0])
				check_irq(irq, 1'b0, $sformatf("after fall %0d of burst", i + 1));
			else
				await_irq(1'b1);
		end
	end
	endtask

	initial
	begin
		$timeformat(-9, 1, " ns", 0);
		void'($urandom(5));
		err_cnt   = 0;
		rst_n     = 1'b0;
		cpu_addr  = 16'h0000;
		cpu_data  = 8'h00;
		cpu_rw    = 1'b1;
		cpu_wr    = 1'b0;
		ppu_addr  = 14'h0000;
		cfg_mir_v = 1'b1;
		fill_table;
		repeat (8) @(posedge mai);
		#1;
		rst_n = 1'b1;
		foreach (vectors[i])
		begin
			case (vectors[i].kind)
				row_write:
					drive_cpu_write(vectors[i].op, vectors[i].data);
				row_prg:
					probe_prg_slot(vectors[i]);
				row_chr:
					probe_chr_addr(vectors[i]);
				row_burst:
					run_a12_burst(vectors[i]);
				row_irq:
					await_irq(vectors[i].exp[0]);
				default:
					report_error($sformatf("row %0d of the table has an unknown kind", i));
			endcase
		end
		if (err_cnt == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/mapper_top.sv
`timescale 1ns/100ps
`default_nettype none

module mapper_top
	import mapper_pkg::*;
(
	input  wire        mai,
	input  wire        rst_n,
	input  wire [15:0] cpu_addr,
	input  wire [7:0]  cpu_data,
	input  wire        cpu_rw,
	input  wire        cpu_wr,
	input  wire [13:0] ppu_addr,
	input  wire        cfg_mir_v,
	output wire [18:0] prg_addr,
	output wire        prg_ce,
	output wire        ram_ce,
	output wire        ram_we,
	output wire [17:0] chr_addr,
	output wire        ciram_a10,
	output wire        ciram_ce,
	output wire        irq
);

	map_op_t   reg_op;
	wire [7:0] reg_data;
	wire [7:0] bank_sel;
	wire [7:0] bank0;
	wire [7:0] bank1;
	wire [7:0] bank2;
	wire [7:0] bank3;
	wire [7:0] bank4;
	wire [7:0] bank5;
	wire [7:0] bank6;
	wire [7:0] bank7;
	wire       mir_h;
	wire       ram_en;
	wire       ram_wp;
	wire       a12_fall;

	bank_regs u_bank_regs (
		.mai       (mai),
		.rst_n     (rst_n),
		.cpu_addr  (cpu_addr),
		.cpu_data  (cpu_data),
		.cpu_rw    (cpu_rw),
		.cpu_wr    (cpu_wr),
		.cfg_mir_v (cfg_mir_v),
		.reg_op    (reg_op),
		.reg_data  (reg_data),
		.bank_sel  (bank_sel),
		.bank0     (bank0),
		.bank1     (bank1),
		.bank2     (bank2),
		.bank3     (bank3),
		.bank4     (bank4),
		.bank5     (bank5),
		.bank6     (bank6),
		.bank7     (bank7),
		.mir_h     (mir_h),
		.ram_en    (ram_en),
		.ram_wp    (ram_wp)
	);

	// scanline clock comes from ppu a12
	a12_edge_fsm u_a12_edge_fsm (
		.mai      (mai),
		.rst_n    (rst_n),
		.ppu_a12  (ppu_addr[12]),
		.a12_fall (a12_fall)
	);

	irq_counter u_irq_counter (
		.mai      (mai),
		.rst_n    (rst_n),
		.reg_op   (reg_op),
		.reg_data (reg_data),
		.a12_fall (a12_fall),
		.irq      (irq)
	);

	addr_translate u_addr_translate (
		.cpu_addr  (cpu_addr),
		.cpu_rw    (cpu_rw),
		.ppu_addr  (ppu_addr),
		.bank_sel  (bank_sel),
		.bank0     (bank0),
		.bank1     (bank1),
		.bank2     (bank2),
		.bank3     (bank3),
		.bank4     (bank4),
		.bank5     (bank5),
		.bank6     (bank6),
		.bank7     (bank7),
		.mir_h     (mir_h),
		.ram_en    (ram_en),
		.ram_wp    (ram_wp),
		.prg_addr  (prg_addr),
		.prg_ce    (prg_ce),
		.ram_ce    (ram_ce),
		.ram_we    (ram_we),
		.chr_addr  (chr_addr),
		.ciram_a10 (ciram_a10),
		.ciram_ce  (ciram_ce)
	);

endmodule

`default_nettype wire

// File: design/addr_translate.sv
`timescale 1ns/100ps
`default_nettype none

`include "mapper_params.svh"

module addr_translate (
	input  wire [15:0] cpu_addr,
	input  wire        cpu_rw,
	input  wire [13:0] ppu_addr,
	input  wire [7:0]  bank_sel,
	input  wire [7:0]  bank0,
	input  wire [7:0]  bank1,
	input  wire [7:0]  bank2,
	input  wire [7:0]  bank3,
	input  wire [7:0]  bank4,
	input  wire [7:0]  bank5,
	input  wire [7:0]  bank6,
	input  wire [7:0]  bank7,
	input  wire        mir_h,
	input  wire        ram_en,
	input  wire        ram_wp,
	output logic [18:0] prg_addr,
	output logic        prg_ce,
	output logic        ram_ce,
	output logic        ram_we,
	output logic [17:0] chr_addr,
	output logic        ciram_a10,
	output logic        ciram_ce
);

	localparam logic [`PRG_BANK_W-1:0] prg_last = '1;
	localparam logic [`PRG_BANK_W-1:0] prg_second_last = prg_last - 1'b1;

	logic [`PRG_BANK_W-1:0] prg_bank;
	logic [`CHR_BANK_W-1:0] chr_bank;
	logic                   prg_mode;
	logic                   chr_mode;

	assign prg_mode = bank_sel[6];
	assign chr_mode = bank_sel[7];

	// four 8 KB slots from $8000
	always_comb
	begin
		case (cpu_addr[14:13])
			2'd0:
				prg_bank = prg_mode ? prg_second_last : bank6[`PRG_BANK_W-1:0];
			2'd1:
				prg_bank = bank7[`PRG_BANK_W-1:0];
			2'd2:
				prg_bank = prg_mode ? bank6[`PRG_BANK_W-1:0] : prg_second_last;
			default:
				prg_bank = prg_last;
		endcase
	end

	// chr_mode picks which pattern table gets the 2 KB pair
	always_comb
	begin
		if (ppu_addr[12] == chr_mode)
		begin
			if (ppu_addr[11])
				chr_bank = {bank1[`CHR_BANK_W-1:1], ppu_addr[10]};
			else
				chr_bank = {bank0[`CHR_BANK_W-1:1], ppu_addr[10]};
		end
		else
		begin
			case (ppu_addr[11:10])
				2'd0:    chr_bank = bank2[`CHR_BANK_W-1:0];
				2'd1:    chr_bank = bank3[`CHR_BANK_W-1:0];
				2'd2:    chr_bank = bank4[`CHR_BANK_W-1:0];
				default: chr_bank = bank5[`CHR_BANK_W-1:0];
			endcase
		end
	end

	assign prg_addr = {prg_bank, cpu_addr[12:0]};
	assign chr_addr = {chr_bank, ppu_addr[9:0]};

	assign prg_ce = cpu_addr[15];
	// work ram window $6000..$7FFF
	assign ram_ce = (cpu_addr[15:13] == 3'b011) & ram_en;
	assign ram_we = ~cpu_rw & ~ram_wp;

	// horizontal mirroring uses a11, vertical a10
	assign ciram_a10 = mir_h ? ppu_addr[11] : ppu_addr[10];
	assign ciram_ce  = ~ppu_addr[13];

endmodule

`default_nettype wire

// File: design/irq_counter.sv
`timescale 1ns/100ps
`default_nettype none

module irq_counter
	import mapper_pkg::*;
(
	input  wire        mai,
	input  wire        rst_n,
	input  map_op_t    reg_op,
	input  wire  [7:0] reg_data,
	input  wire        a12_fall,
	output logic       irq
);

	logic [7:0] irq_latch;
	logic [7:0] irq_count;
	logic [7:0] count_next;
	logic [2:0] prescale;
	logic       reload;
	logic       irq_en;
	logic       cnt_clk;
	logic       fire;

	// acclaim variant, counter steps once every eight a12 falls
	assign cnt_clk = a12_fall & (prescale == 3'd7);

	always_comb
	begin
		if (irq_count == 8'd0 || reload)
			count_next = irq_latch;
		else
			count_next = irq_count - 8'd1;
	end

	always_ff @(posedge mai or negedge rst_n)
	begin
		if (!rst_n)
		begin
			irq_latch <= 8'd0;
			irq_count <= 8'd0;
			prescale  <= 3'd0;
			reload    <= 1'b0;
			irq_en    <= 1'b0;
			fire      <= 1'b0;
			irq       <= 1'b0;
		end
		else
		begin
			fire <= 1'b0;
			if (a12_fall)
				prescale <= prescale + 3'd1;
			if (cnt_clk)
			begin
				irq_count <= count_next;
				reload    <= 1'b0;
				fire      <= (count_next == 8'd0) & irq_en;
			end
			// irq follows the zero count by one cycle
			if (fire & irq_en)
				irq <= 1'b1;
			// register writes win over the counter in the same cycle
			case (reg_op)
				op_irq_latch:
					irq_latch <= reg_data;
				op_irq_reload:
				begin
					reload   <= 1'b1;
					prescale <= 3'd0;
				end
				op_irq_disable:
				begin
					irq_en <= 1'b0;
					irq    <= 1'b0;
				end
				op_irq_enable:
					irq_en <= 1'b1;
				default:
					;
			endcase
		end
	end

	// a disable write always acknowledges a pending irq
	assert property (@(posedge mai) disable iff (!rst_n)
		reg_op == op_irq_disable |=> !irq);

endmodule

`default_nettype wire

// File: design/a12_edge_fsm.sv
`timescale 1ns/100ps
`default_nettype none

`include "mapper_params.svh"

module a12_edge_fsm
	import mapper_pkg::*;
(
	input  wire  mai,
	input  wire  rst_n,
	input  wire  ppu_a12,
	output logic a12_fall
);

	localparam logic [`A12_CNT_W-1:0] high_last = `A12_MIN_HIGH - 1;
	localparam logic [`A12_CNT_W-1:0] high_first = {{(`A12_CNT_W-1){1'b0}}, 1'b1};

	a12_state_t            state;
	logic [`A12_CNT_W-1:0] high_cnt;

	always_ff @(posedge mai or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= a12_low;
			high_cnt <= '0;
			a12_fall <= 1'b0;
		end
		else
		begin
			a12_fall <= 1'b0;
			case (state)
				a12_low:
				begin
					if (ppu_a12)
					begin
						state    <= a12_high_wait;
						high_cnt <= high_first;
					end
				end
				// short highs drop back without a pulse
				a12_high_wait:
				begin
					if (!ppu_a12)
						state <= a12_low;
					else if (high_cnt == high_last)
						state <= a12_high_valid;
					else
						high_cnt <= high_cnt + 1'b1;
				end
				a12_high_valid:
				begin
					if (!ppu_a12)
					begin
						state    <= a12_low;
						a12_fall <= 1'b1;
					end
				end
				default:
					state <= a12_low;
			endcase
		end
	end

	// one pulse per qualified fall
	assert property (@(posedge mai) disable iff (!rst_n)
		a12_fall |=> !a12_fall);

endmodule

`default_nettype wire

// File: design/bank_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "mapper_params.svh"

module bank_regs
	import mapper_pkg::*;
(
	input  wire        mai,
	input  wire        rst_n,
	input  wire [15:0] cpu_addr,
	input  wire [7:0]  cpu_data,
	input  wire        cpu_rw,
	input  wire        cpu_wr,
	input  wire        cfg_mir_v,
	output map_op_t    reg_op,
	output logic [7:0] reg_data,
	output logic [7:0] bank_sel,
	output logic [7:0] bank0,
	output logic [7:0] bank1,
	output logic [7:0] bank2,
	output logic [7:0] bank3,
	output logic [7:0] bank4,
	output logic [7:0] bank5,
	output logic [7:0] bank6,
	output logic [7:0] bank7,
	output logic       mir_h,
	output logic       ram_en,
	output logic       ram_wp
);

	logic       wr_en;
	map_op_t    map_op;
	logic [7:0] bank_r [0:7];

	// mapper registers live at $8000 and up
	assign wr_en = cpu_wr & ~cpu_rw & cpu_addr[15];

	always_comb
	begin
		if (wr_en)
			map_op = map_op_t'({cpu_addr[15:13], cpu_addr[0]});
		else
			map_op = op_none;
	end

	always_ff @(posedge mai or negedge rst_n)
	begin
		if (!rst_n)
		begin
			bank_sel  <= 8'h00;
			mir_h     <= ~cfg_mir_v;
			ram_en    <= 1'b0;
			ram_wp    <= 1'b0;
			bank_r[0] <= `BANK_RESET_0;
			bank_r[1] <= `BANK_RESET_1;
			bank_r[2] <= `BANK_RESET_2;
			bank_r[3] <= `BANK_RESET_3;
			bank_r[4] <= `BANK_RESET_4;
			bank_r[5] <= `BANK_RESET_5;
			bank_r[6] <= `BANK_RESET_6;
			bank_r[7] <= `BANK_RESET_7;
		end
		else
		begin
			case (map_op)
				op_bank_select:
					bank_sel <= cpu_data;
				// target register picked by the low bits of bank_sel
				op_bank_data:
					bank_r[bank_sel[2:0]] <= cpu_data;
				op_mirror:
					mir_h <= cpu_data[0];
				// bit 7 enables work ram, bit 6 write-protects it
				op_ram_protect:
				begin
					ram_en <= cpu_data[7];
					ram_wp <= cpu_data[6];
				end
				default:
					;
			endcase
		end
	end

	// irq writes go on to the counter one cycle later
	always_ff @(posedge mai or negedge rst_n)
	begin
		if (!rst_n)
			reg_op <= op_none;
		else if (map_op inside {op_irq_latch, op_irq_reload, op_irq_disable, op_irq_enable})
			reg_op <= map_op;
		else
			reg_op <= op_none;
	end

	always_ff @(posedge mai)
	begin
		if (wr_en)
			reg_data <= cpu_data;
	end

	assign bank0 = bank_r[0];
	assign bank1 = bank_r[1];
	assign bank2 = bank_r[2];
	assign bank3 = bank_r[3];
	assign bank4 = bank_r[4];
	assign bank5 = bank_r[5];
	assign bank6 = bank_r[6];
	assign bank7 = bank_r[7];

	// the irq block only ever sees an opcode right after a strobe
	assert property (@(posedge mai) disable iff (!rst_n)
		!$past(cpu_wr) |-> reg_op == op_none);

endmodule

`default_nettype wire

// File: design/mapper_pkg.sv
`default_nettype none

package mapper_pkg;

	// cpu register operation, coded as {addr[15:13], addr[0]}
	// so a write at $8000 or above maps onto it directly
	typedef enum logic [3:0] {
		op_none        = 4'h0,
		op_bank_select = 4'h8,
		op_bank_data   = 4'h9,
		op_mirror      = 4'hA,
		op_ram_protect = 4'hB,
		op_irq_latch   = 4'hC,
		op_irq_reload  = 4'hD,
		op_irq_disable = 4'hE,
		op_irq_enable  = 4'hF
	} map_op_t;

	// ppu a12 glitch filter
	typedef enum logic [1:0] {
		a12_low        = 2'd0,
		a12_high_wait  = 2'd1,
		a12_high_valid = 2'd2
	} a12_state_t;

endpackage

`default_nettype wire

// File: design/mapper_params.svh
`ifndef MAPPER_PARAMS_SVH
`define MAPPER_PARAMS_SVH

// prg bank number, 8 KB banks over 512 KB
`define PRG_BANK_W 6

// chr bank number, 1 KB banks
`define CHR_BANK_W 8

// mai cycles a12 must stay high before its fall counts
`define A12_MIN_HIGH 4

// width of the high-time counter in the a12 filter
`define A12_CNT_W 3

// bank data registers after reset
// r0/r1 are the 2 KB chr banks, r2..r5 the 1 KB chr banks
// r6/r7 are the switchable prg banks
`define BANK_RESET_0 8'd0
`define BANK_RESET_1 8'd2
`define BANK_RESET_2 8'd4
`define BANK_RESET_3 8'd5
`define BANK_RESET_4 8'd6
`define BANK_RESET_5 8'd7
`define BANK_RESET_6 8'd0
`define BANK_RESET_7 8'd1

`endif
